//--- hw/camera_spi_pkg.sv
// Opcode enum, pixel, metering and encoded byte structs, counter width constant
package camera_spi_pkg;

    // Width of the capture byte counters and the read pointer
    localparam int byte_count_width = 16;

    // Host command set, first byte of every transaction
    typedef enum logic [7:0] {
        op_capture         = 8'h20,
        op_bytes_available = 8'h21,
        op_read_data       = 8'h22,
        op_zoom            = 8'h23,
        op_pan             = 8'h24,
        op_metering        = 8'h25,
        op_compression     = 8'h26
    } spi_opcode_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_pixel_t;

    // Field order is the order the host reads them in
    typedef struct packed {
        logic [7:0] red_center;
        logic [7:0] green_center;
        logic [7:0] blue_center;
        logic [7:0] red_average;
        logic [7:0] green_average;
        logic [7:0] blue_average;
    } metering_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } encoded_byte_t;

endpackage

//--- hw/spi_peripheral.sv
// SPI mode 0 byte peripheral with opcode level, operand strobe and response shifter
module spi_peripheral (
    input  logic                                         clock_in,
    input  logic                                         reset_n_in,

    input  logic                                         spi_sclk,
    input  logic                                         spi_cs_n,
    input  logic                                         spi_copi,
    output logic                                         spi_cipo,

    output logic [7:0]                                   opcode,
    output logic                                         opcode_valid,
    output logic [7:0]                                   operand,
    output logic                                         operand_valid,
    output logic [camera_spi_pkg::byte_count_width-1:0]  operand_count,
    input  logic [7:0]                                   response
);

    typedef enum logic [1:0] {
        state_idle,
        state_opcode,
        state_operands
    } state_t;

    state_t state;

    // Two-flop synchronisers for the pins
    logic [1:0] sclk_sync;
    logic [1:0] cs_n_sync;
    logic [1:0] copi_sync;

    // Previous synchronised values for edge detection
    logic sclk_q;
    logic cs_n_q;

    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_count;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic [7:0] rx_byte;

    assign sclk_rise = sclk_sync[1] & ~sclk_q;
    assign sclk_fall = ~sclk_sync[1] & sclk_q;

    // Completed byte including the bit sampled on this edge
    assign rx_byte = {rx_shift[6:0], copi_sync[1]};

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            sclk_sync     <= 2'b00;
            cs_n_sync     <= 2'b11;
            copi_sync     <= 2'b00;
            sclk_q        <= 1'b0;
            cs_n_q        <= 1'b1;
            state         <= state_idle;
            bit_count     <= 3'd0;
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            operand_count <= '0;
            spi_cipo      <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n};
            copi_sync <= {copi_sync[0], spi_copi};
            sclk_q    <= sclk_sync[1];
            cs_n_q    <= cs_n_sync[1];

            operand_valid <= 1'b0;
            if (operand_valid) begin
                operand_count <= operand_count + 1'b1;
            end

            if (cs_n_sync[1]) begin
                state         <= state_idle;
                bit_count     <= 3'd0;
                opcode_valid  <= 1'b0;
                operand_count <= '0;
                spi_cipo      <= 1'b0;
            end else begin
                // Chip select just fell
                if (cs_n_q) begin
                    state    <= state_opcode;
                    tx_shift <= 8'h00;
                    spi_cipo <= 1'b0;
                end

                if (sclk_rise) begin
                    rx_shift  <= rx_byte;
                    bit_count <= bit_count + 3'd1;
                    if (bit_count == 3'd7) begin
                        case (state)
                            state_opcode: begin
                                opcode       <= rx_byte;
                                opcode_valid <= 1'b1;
                                state        <= state_operands;
                            end
                            state_operands: begin
                                operand       <= rx_byte;
                                operand_valid <= 1'b1;
                            end
                            default: begin
                            end
                        endcase
                    end
                end

                // New byte starts on the first falling edge after a boundary
                if (sclk_fall) begin
                    if (bit_count == 3'd0) begin
                        spi_cipo <= response[7];
                        tx_shift <= {response[6:0], 1'b0};
                    end else begin
                        spi_cipo <= tx_shift[7];
                        tx_shift <= {tx_shift[6:0], 1'b0};
                    end
                end
            end
        end
    end

endmodule

//--- hw/spi_registers.sv
// Opcode decoder with response mux, capture read pointer and camera control outputs
module spi_registers (
    input  logic                                         clock_in,
    input  logic                                         reset_n_in,

    input  logic [7:0]                                   opcode,
    input  logic                                         opcode_valid,
    input  logic [7:0]                                   operand,
    input  logic                                         operand_valid,
    input  logic [camera_spi_pkg::byte_count_width-1:0]  operand_count,
    output logic [7:0]                                   response,

    output logic [camera_spi_pkg::byte_count_width-1:0]  read_pointer,
    input  logic [7:0]                                   read_data,
    input  logic [camera_spi_pkg::byte_count_width-1:0]  bytes_available,

    input  camera_spi_pkg::metering_t                    metering,

    output logic                                         start_capture,
    output logic [3:0]                                   compression_factor
);

    import camera_spi_pkg::*;

    spi_opcode_t                 command;
    logic [byte_count_width-1:0] bytes_remaining;
    logic                        opcode_valid_q;
    logic                        opcode_start;

    assign command         = spi_opcode_t'(opcode);
    assign bytes_remaining = bytes_available - read_pointer;
    assign opcode_start    = opcode_valid & ~opcode_valid_q;

    // Metering byte for a given operand index, in struct order
    function automatic logic [7:0] metering_byte(
        input metering_t                   values,
        input logic [byte_count_width-1:0] index
    );
        logic [7:0] result;
        case (index)
            0:       result = values.red_center;
            1:       result = values.green_center;
            2:       result = values.blue_center;
            3:       result = values.red_average;
            4:       result = values.green_average;
            5:       result = values.blue_average;
            default: result = 8'h00;
        endcase
        return result;
    endfunction

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            response           <= 8'h00;
            read_pointer       <= '0;
            start_capture      <= 1'b0;
            compression_factor <= 4'h0;
            opcode_valid_q     <= 1'b0;
        end else begin
            opcode_valid_q <= opcode_valid;
            start_capture  <= 1'b0;
            response       <= 8'h00;

            if (opcode_valid) begin
                case (command)
                    op_capture: begin
                        // Single pulse per transaction
                        if (opcode_start) begin
                            start_capture <= 1'b1;
                            read_pointer  <= '0;
                        end
                    end

                    op_bytes_available: begin
                        if (operand_count == 0) begin
                            response <= bytes_remaining[15:8];
                        end else if (operand_count == 1) begin
                            response <= bytes_remaining[7:0];
                        end
                    end

                    op_read_data: begin
                        response <= read_data;
                        // Pointer holds at the end of the stream
                        if (operand_valid && read_pointer < bytes_available) begin
                            read_pointer <= read_pointer + 1'b1;
                        end
                    end

                    op_metering: begin
                        response <= metering_byte(metering, operand_count);
                    end

                    op_compression: begin
                        if (operand_valid && operand_count == '0) begin
                            compression_factor <= operand[3:0];
                        end
                    end

                    // Zoom and pan operands are consumed with no effect
                    op_zoom, op_pan: begin
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- hw/capture_buffer.sv
// Capture byte memory with write counter and clamped read port
module capture_buffer #(
    parameter int buffer_depth = 256
) (
    input  logic                                         clock_in,
    input  logic                                         reset_n_in,

    input  logic                                         start_capture,
    input  camera_spi_pkg::encoded_byte_t                encoded,
    input  logic [camera_spi_pkg::byte_count_width-1:0]  read_pointer,
    output logic [7:0]                                   read_data,
    output logic [camera_spi_pkg::byte_count_width-1:0]  bytes_available
);

    import camera_spi_pkg::*;

    localparam int address_width = $clog2(buffer_depth);

    logic [7:0]                  memory [buffer_depth];
    logic [byte_count_width-1:0] write_count;
    logic [byte_count_width-1:0] read_address;
    logic                        full;
    logic                        write_enable;

    assign full         = write_count == byte_count_width'(buffer_depth);
    assign write_enable = encoded.valid & ~start_capture & ~full;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            write_count <= '0;
        end else if (start_capture) begin
            write_count <= '0;
        end else if (write_enable) begin
            write_count <= write_count + 1'b1;
        end
    end

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            memory[write_count[address_width-1:0]] <= encoded.data;
        end
    end

    // Reads past the stream end return the last stored byte
    always_comb begin
        if (read_pointer < write_count) begin
            read_address = read_pointer;
        end else if (write_count != '0) begin
            read_address = write_count - 1'b1;
        end else begin
            read_address = '0;
        end
    end

    assign read_data       = memory[read_address[address_width-1:0]];
    assign bytes_available = write_count;

endmodule

//--- hw/metering_unit.sv
// Frame position tracker and centre window and full frame RGB averager
module metering_unit #(
    parameter int frame_width  = 8,
    parameter int frame_height = 8
) (
    input  logic                        clock_in,
    input  logic                        reset_n_in,

    input  logic                        frame_start,
    input  camera_spi_pkg::rgb_pixel_t  pixel,
    input  logic                        pixel_valid,
    output camera_spi_pkg::metering_t   metering
);

    localparam int column_width = $clog2(frame_width);
    localparam int row_width    = $clog2(frame_height);
    // Pixel counts are powers of two so the averages are shifts
    localparam int full_shift   = column_width + row_width;
    localparam int center_shift = full_shift - 2;
    localparam int full_width   = 8 + full_shift;
    localparam int center_width = 8 + center_shift;

    logic [column_width-1:0] column;
    logic [row_width-1:0]    row;
    logic                    in_center;
    logic                    last_column;
    logic                    last_pixel;
    logic [7:0]              channel [3];

    // Index 0 red, 1 green, 2 blue
    logic [full_width-1:0]   full_sum [3];
    logic [full_width-1:0]   full_next [3];
    logic [center_width-1:0] center_sum [3];
    logic [center_width-1:0] center_next [3];

    assign channel[0] = pixel.red;
    assign channel[1] = pixel.green;
    assign channel[2] = pixel.blue;

    // Middle half in both directions
    assign in_center = column >= column_width'(frame_width / 4) &&
                       column <  column_width'(frame_width / 4 + frame_width / 2) &&
                       row    >= row_width'(frame_height / 4) &&
                       row    <  row_width'(frame_height / 4 + frame_height / 2);

    assign last_column = column == column_width'(frame_width - 1);
    assign last_pixel  = last_column && row == row_width'(frame_height - 1);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            full_next[i]   = full_sum[i] + full_width'(channel[i]);
            center_next[i] = in_center ? center_sum[i] + center_width'(channel[i])
                                       : center_sum[i];
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            column   <= '0;
            row      <= '0;
            full_sum   <= '{default: '0};
            center_sum <= '{default: '0};
            metering <= '0;
        end else if (frame_start) begin
            column     <= '0;
            row        <= '0;
            full_sum   <= '{default: '0};
            center_sum <= '{default: '0};
        end else if (pixel_valid) begin
            if (last_pixel) begin
                column     <= '0;
                row        <= '0;
                full_sum   <= '{default: '0};
                center_sum <= '{default: '0};
                metering.red_center    <= center_next[0][center_width-1 -: 8];
                metering.green_center  <= center_next[1][center_width-1 -: 8];
                metering.blue_center   <= center_next[2][center_width-1 -: 8];
                metering.red_average   <= full_next[0][full_width-1 -: 8];
                metering.green_average <= full_next[1][full_width-1 -: 8];
                metering.blue_average  <= full_next[2][full_width-1 -: 8];
            end else begin
                full_sum   <= full_next;
                center_sum <= center_next;
                column     <= last_column ? '0 : column + 1'b1;
                if (last_column) begin
                    row <= row + 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/camera_spi_subsystem.sv
// Camera SPI top level with peripheral, registers, capture buffer and metering
module camera_spi_subsystem #(
    parameter int buffer_depth = 256,
    parameter int frame_width  = 8,
    parameter int frame_height = 8
) (
    input  logic                           clock_in,
    input  logic                           reset_n_in,

    input  logic                           spi_sclk,
    input  logic                           spi_cs_n,
    input  logic                           spi_copi,
    output logic                           spi_cipo,

    input  camera_spi_pkg::rgb_pixel_t     pixel,
    input  logic                           pixel_valid,
    input  logic                           frame_start,
    input  camera_spi_pkg::encoded_byte_t  encoded,

    output logic                           start_capture,
    output logic [3:0]                     compression_factor
);

    import camera_spi_pkg::*;

    logic [7:0]                  opcode;
    logic                        opcode_valid;
    logic [7:0]                  operand;
    logic                        operand_valid;
    logic [byte_count_width-1:0] operand_count;
    logic [7:0]                  response;
    logic [byte_count_width-1:0] read_pointer;
    logic [7:0]                  read_data;
    logic [byte_count_width-1:0] bytes_available;
    metering_t                   metering;

    spi_peripheral spi_peripheral_i (
        .clock_in, .reset_n_in,
        .spi_sclk, .spi_cs_n, .spi_copi, .spi_cipo,
        .opcode, .opcode_valid, .operand, .operand_valid, .operand_count,
        .response
    );

    spi_registers spi_registers_i (
        .clock_in, .reset_n_in,
        .opcode, .opcode_valid, .operand, .operand_valid, .operand_count,
        .response,
        .read_pointer, .read_data, .bytes_available,
        .metering,
        .start_capture, .compression_factor
    );

    capture_buffer #(.buffer_depth(buffer_depth)) capture_buffer_i (
        .clock_in, .reset_n_in,
        .start_capture, .encoded, .read_pointer, .read_data, .bytes_available
    );

    metering_unit #(.frame_width(frame_width), .frame_height(frame_height)) metering_unit_i (
        .clock_in, .reset_n_in,
        .frame_start, .pixel, .pixel_valid, .metering
    );

endmodule

//--- test/tb_clock_gen.sv
// Free-running testbench clock source
module tb_clock_gen #(
    parameter int half_period_ns = 10
) (
    output logic clock
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #(half_period_ns) clock = ~clock;
    end

endmodule

//--- test/camera_spi_checker.sv
// Concurrent assertions on the SPI peripheral strobes and their bind
module camera_spi_checker (
    input logic clock_in,
    input logic reset_n_in,
    input logic cs_n_delayed,
    input logic opcode_valid,
    input logic operand_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    operand_single_cycle: assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        operand_valid |=> !operand_valid
    ) else $error("operand_valid lasted more than one cycle");

    operand_inside_command: assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        operand_valid |-> opcode_valid
    ) else $error("operand_valid seen without opcode_valid");

    // Synchronised chip select, one clock behind the pin pipeline
    opcode_idle_when_deselected: assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        cs_n_delayed |-> !opcode_valid
    ) else $error("opcode_valid high while chip select is high");

endmodule

bind spi_peripheral camera_spi_checker camera_spi_checker_i (
    .clock_in      (clock_in),
    .reset_n_in    (reset_n_in),
    .cs_n_delayed  (cs_n_q),
    .opcode_valid  (opcode_valid),
    .operand_valid (operand_valid)
);

//--- test/camera_spi_tb.sv
// Camera SPI subsystem testbench with SPI host model, pixel and byte streams, response checks
module camera_spi_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import camera_spi_pkg::*;

    localparam int pixel_count   = 64;
    localparam int encoded_count = 40;
    localparam int sclk_half     = 10;
    // Longest run is roughly 11000 cycles
    localparam int timeout_cycles = 20000;

    logic          clock_in;
    logic          reset_n_in;
    logic          spi_sclk;
    logic          spi_cs_n;
    logic          spi_copi;
    logic          spi_cipo;
    rgb_pixel_t    pixel;
    logic          pixel_valid;
    logic          frame_start;
    encoded_byte_t encoded;
    logic          start_capture;
    logic [3:0]    compression_factor;

    logic [23:0] test_vectors [110];
    logic [7:0]  tx_bytes [48];
    logic [7:0]  rx_bytes [48];
    int          capture_pulses = 0;
    int          cycle_count = 0;

    tb_clock_gen #(.half_period_ns(10)) clock_gen_i (.clock(clock_in));

    camera_spi_subsystem #(
        .buffer_depth (256),
        .frame_width  (8),
        .frame_height (8)
    ) camera_spi_subsystem_i (
        .clock_in, .reset_n_in,
        .spi_sclk, .spi_cs_n, .spi_copi, .spi_cipo,
        .pixel, .pixel_valid, .frame_start, .encoded,
        .start_capture, .compression_factor
    );

    always @(posedge clock_in) begin
        if (start_capture) begin
            capture_pulses <= capture_pulses + 1;
        end
    end

    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "Value check did not match");
        end
    endtask

    // Mode 0 host, MSB first, CIPO sampled on the rising edge
    task automatic spi_transaction(input int byte_total);
        spi_cs_n <= 1'b0;
        repeat (sclk_half) @(posedge clock_in);
        for (int i = 0; i < byte_total; i++) begin
            for (int b = 7; b >= 0; b--) begin
                spi_copi <= tx_bytes[i][b];
                repeat (sclk_half) @(posedge clock_in);
                spi_sclk <= 1'b1;
                rx_bytes[i][b] = spi_cipo;
                repeat (sclk_half) @(posedge clock_in);
                spi_sclk <= 1'b0;
            end
        end
        repeat (sclk_half) @(posedge clock_in);
        spi_cs_n <= 1'b1;
        repeat (sclk_half) @(posedge clock_in);
    endtask

    task automatic run_command(input spi_opcode_t command, input int operand_total,
                               input logic [7:0] operand_value);
        tx_bytes[0] = command;
        for (int k = 1; k <= operand_total; k++) begin
            tx_bytes[k] = operand_value;
        end
        spi_transaction(operand_total + 1);
    endtask

    task automatic check_remaining(input int expected_count);
        run_command(op_bytes_available, 2, 8'h00);
        check_value(rx_bytes[1], 8'(expected_count >> 8), "bytes available high byte");
        check_value(rx_bytes[2], 8'(expected_count), "bytes available low byte");
    endtask

    task automatic stream_encoded();
        for (int i = 0; i < encoded_count; i++) begin
            @(posedge clock_in);
            encoded <= '{valid: 1'b1, data: test_vectors[pixel_count + i][7:0]};
            @(posedge clock_in);
            encoded.valid <= 1'b0;
        end
        repeat (4) @(posedge clock_in);
    endtask

    task automatic stream_frame();
        @(posedge clock_in);
        frame_start <= 1'b1;
        for (int i = 0; i < pixel_count; i++) begin
            @(posedge clock_in);
            frame_start <= 1'b0;
            pixel       <= rgb_pixel_t'(test_vectors[i]);
            pixel_valid <= 1'b1;
        end
        @(posedge clock_in);
        pixel_valid <= 1'b0;
        repeat (4) @(posedge clock_in);
    endtask

    initial begin
        int          read_count;
        logic [7:0]  compression_value;

        reset_n_in  = 1'b0;
        spi_sclk    = 1'b0;
        spi_cs_n    = 1'b1;
        spi_copi    = 1'b0;
        pixel       = '0;
        pixel_valid = 1'b0;
        frame_start = 1'b0;
        encoded     = '0;
        void'($urandom(80));
        $readmemh("test/camera_spi_testdata.txt", test_vectors);

        repeat (2) @(posedge clock_in);
        reset_n_in <= 1'b1;
        @(posedge clock_in);
        check_value({7'd0, start_capture}, 8'h00, "start_capture after reset");
        check_value({4'h0, compression_factor}, 8'h00, "compression_factor after reset");

        run_command(op_capture, 0, 8'h00);
        check_value(8'(capture_pulses), 8'd1, "start_capture pulses per capture");

        compression_value = 8'($urandom);
        run_command(op_compression, 1, compression_value);
        check_value({4'h0, compression_factor}, {4'h0, compression_value[3:0]},
                    "compression_factor");

        stream_encoded();
        check_remaining(encoded_count);

        read_count = 1 + int'($urandom % 40);
        run_command(op_read_data, read_count, 8'h00);
        for (int k = 0; k < read_count; k++) begin
            check_value(rx_bytes[k + 1], test_vectors[pixel_count + k][7:0], "read data byte");
        end
        check_remaining(encoded_count - read_count);

        stream_frame();
        run_command(op_zoom, 2, 8'h5a);
        run_command(op_pan, 2, 8'ha5);
        check_remaining(encoded_count - read_count);
        check_value({4'h0, compression_factor}, {4'h0, compression_value[3:0]},
                    "compression_factor after zoom and pan");
        check_value(8'(capture_pulses), 8'd1, "start_capture pulses after zoom and pan");

        run_command(op_metering, 6, 8'h00);
        for (int k = 0; k < 6; k++) begin
            check_value(rx_bytes[k + 1], test_vectors[pixel_count + encoded_count + k][7:0],
                        "metering byte");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- camera_spi_subsystem.f
hw/camera_spi_pkg.sv
hw/spi_peripheral.sv
hw/spi_registers.sv
hw/capture_buffer.sv
hw/metering_unit.sv
hw/camera_spi_subsystem.sv
test/tb_clock_gen.sv
test/camera_spi_checker.sv
test/camera_spi_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the camera SPI testbench with Verilator and run it from the project root
verilator --binary --timing --assert -f camera_spi_subsystem.f \
    --top-module camera_spi_tb -o camera_spi_sim \
    && ./obj_dir/camera_spi_sim \
    || exit 1

//--- test/camera_spi_testdata.txt
// Words 0 to 63: 8x8 pixel frame row by row, red green blue; 64 to 103: encoded bytes
// Words 104 to 109: expected red, green, blue centre and red, green, blue full averages
0010f0 0210e8 0810e0 1210d8 2010d0 3210c8 4810c0 6210b8
0014ec 0214e4 0814dc 1214d4 2014cc 3214c4 4814bc 6214b4
0020e8 0220e0 0820d8 1220d0 2020c8 3220c0 4820b8 6220b0
0034e4 0234dc 0834d4 1234cc 2034c4 3234bc 4834b4 6234ac
0050e0 0250d8 0850d0 1250c8 2050c0 3250b8 4850b0 6250a8
0074dc 0274d4 0874cc 1274c4 2074bc 3274b4 4874ac 6274a4
00a0d8 02a0d0 08a0c8 12a0c0 20a0b8 32a0b0 48a0a8 62a0a0
00d4d4 02d4cc 08d4c4 12d4bc 20d4b4 32d4ac 48d4a4 62d49c
3c a5 17 e2 5b 90 0d 7f
c4 28 b1 46 f9 63 8a 1e
d7 52 04 bb 39 6e a0 f5
81 2d c9 74 18 e6 5f 93
0a b7 4c d2 67 fe 35 89
1b 46 c6 23 56 c6
